// ==== src.f ====
+incdir+rtl
+incdir+verification
rtl/issue_pkg.sv
rtl/staging_buffer.sv
rtl/reg_scoreboard.sv
rtl/issue_arbiter.sv
rtl/stall_monitor.sv
rtl/issue_stage.sv
verification/issue_stage_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = issue_stage_tb
FILE_LIST = src.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/issue_model.svh ====
// Issue stage reference model

localparam int num_warps = `ISSUE_NUM_WARPS;
localparam int num_regs  = `ISSUE_NUM_REGS;

// Instructions not yet offered, and accepted ones not yet issued, in program order
issue_instr_t        stream_q[num_warps][$];
issue_instr_t        expect_q[num_warps][$];
logic [num_regs-1:0] pending_regs[num_warps];
logic [7:0]          next_tag[num_warps];
writeback_t          wb_q[$];
int                  wb_due[$];
logic [31:0]         lfsr_state;

// Fibonacci LFSR with taps 32, 22, 2 and 1
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_bit()};
    end
    return v;
endfunction

// Registers an instruction reads, plus rd when it writes one
function automatic logic [num_regs-1:0] touched_regs(input issue_instr_t instr);
    logic [num_regs-1:0] m;
    m = '0;
    if (instr.wb) m[instr.rd] = 1'b1;
    if (instr.used_rs[0]) m[instr.rs1] = 1'b1;
    if (instr.used_rs[1]) m[instr.rs2] = 1'b1;
    if (instr.used_rs[2]) m[instr.rs3] = 1'b1;
    return m;
endfunction

// Operands come from r0 to r7 so most instructions collide with an earlier one
function automatic void add_stream(input int w, input int count, input logic allow_wb);
    issue_instr_t instr;
    for (int i = 0; i < count; i++) begin
        instr.tag     = next_tag[w];
        instr.op      = 6'(rand_bits(6));
        instr.wb      = allow_wb && (rand_bits(1) != 0);
        instr.used_rs = 3'(rand_bits(3));
        instr.rd      = reg_idx_t'(rand_bits(3));
        instr.rs1     = reg_idx_t'(rand_bits(3));
        instr.rs2     = reg_idx_t'(rand_bits(3));
        instr.rs3     = reg_idx_t'(rand_bits(3));
        next_tag[w]   = next_tag[w] + 8'd1;
        stream_q[w].push_back(instr);
    end
endfunction

// ==== verification/issue_stage_tb.sv ====
// Issue stage testbench
`timescale 1ns/1ps
`include "issue_settings.svh"

module issue_stage_tb import issue_pkg::*; ();

    `include "issue_model.svh"

    localparam int clk_period       = 40;
    localparam int drive_delay      = 2;
    localparam int quiet_per_warp   = 40;
    localparam int random_per_warp  = 120;
    localparam int wb_hold          = `ISSUE_STALL_TIMEOUT + 10;
    // Worst case for one instruction with hazards, write delays and back-pressure
    localparam int cycles_per_instr = 30;
    localparam int watchdog_cycles  =
        (num_warps * (quiet_per_warp + random_per_warp) + 2) * cycles_per_instr + 4 * wb_hold;

    logic                         clk;
    logic                         reset;
    logic [num_warps-1:0]         in_valid;
    issue_instr_t [num_warps-1:0] in_instr;
    logic [num_warps-1:0]         in_ready;
    logic                         out_valid;
    issued_instr_t                out_instr;
    logic                         out_ready;
    logic                         wb_valid;
    writeback_t                   wb_data;
    logic [`ISSUE_CTR_BITS-1:0]   stall_count;
    logic [num_warps-1:0]         stall_timeout;

    int                           cyc;
    int                           test_errors;
    int                           pass_count;
    int                           fail_count;
    int                           wb_delay_fixed;
    int                           issued_count[num_warps];
    logic [num_warps-1:0]         taken;
    logic                         backpressure;
    logic                         steady_inputs;
    logic                         quiet_stall;
    logic [`ISSUE_CTR_BITS-1:0]   stall_base;
    logic [`ISSUE_CTR_BITS-1:0]   stall_prev;
    logic                         prev_valid;
    logic                         prev_ready;
    issued_instr_t                prev_out;

    issue_stage issue_stage_inst (.*);

    task automatic check_equal(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("%s: ok", name);
        end else begin
            fail_count++;
            $display("%s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // Inputs change a little after the rising edge
    task automatic drive_inputs();
        int         idx;
        writeback_t wbt;
        cyc++;
        for (int w = 0; w < num_warps; w++) begin
            if (taken[w] || !in_valid[w]) begin
                in_valid[w] = 1'b0;
                if (stream_q[w].size() > 0 && (steady_inputs || rand_bits(2) != 0)) begin
                    in_valid[w] = 1'b1;
                    in_instr[w] = stream_q[w][0];
                end
            end
        end
        taken     = '0;
        out_ready = backpressure ? (rand_bits(2) != 0) : 1'b1;
        wb_valid  = 1'b0;
        idx       = -1;
        for (int i = 0; i < wb_q.size(); i++) begin
            if (idx < 0 && wb_due[i] <= cyc) idx = i;
        end
        if (idx >= 0) begin
            wbt = wb_q[idx];
            wb_valid = 1'b1;
            wb_data  = wbt;
            pending_regs[wbt.wid][wbt.rd] = 1'b0;
            wb_q.delete(idx);
            wb_due.delete(idx);
        end
    endtask

    // Sampled at the falling edge, where every output is settled
    task automatic observe();
        issue_instr_t head;
        writeback_t   wbt;
        int           w;
        for (int k = 0; k < num_warps; k++) begin
            if (in_valid[k] && in_ready[k]) begin
                taken[k] = 1'b1;
                expect_q[k].push_back(stream_q[k].pop_front());
            end
        end
        if (prev_valid && !prev_ready) begin
            check_equal("out_valid held under back-pressure", 64'(out_valid), 64'(1));
            check_equal("out_instr held under back-pressure", 64'(out_instr), 64'(prev_out));
        end
        if (out_valid && out_ready) begin
            w = int'(out_instr.wid);
            check_equal($sformatf("warp %0d has an instruction outstanding", w),
                        64'(expect_q[w].size() != 0), 64'(1));
            if (expect_q[w].size() != 0) begin
                head = expect_q[w].pop_front();
                check_equal($sformatf("warp %0d issue order", w),
                            64'(out_instr.instr), 64'(head));
                check_equal($sformatf("warp %0d pending registers named", w),
                            64'(pending_regs[w] & touched_regs(out_instr.instr)), 64'(0));
                if (out_instr.instr.wb) begin
                    pending_regs[w][out_instr.instr.rd] = 1'b1;
                    wbt.wid = out_instr.wid;
                    wbt.rd  = out_instr.instr.rd;
                    wb_q.push_back(wbt);
                    wb_due.push_back(cyc + ((wb_delay_fixed > 0) ?
                                            wb_delay_fixed : 1 + int'(rand_bits(3))));
                end
                issued_count[w]++;
            end
        end
        check_equal("stall_count never decreases", 64'(stall_count >= stall_prev), 64'(1));
        if (quiet_stall) begin
            check_equal("stall_count without writes", 64'(stall_count), 64'(stall_base));
        end
        stall_prev = stall_count;
        prev_valid = out_valid;
        prev_ready = out_ready;
        prev_out   = out_instr;
    endtask

    task automatic run_cycle();
        @(posedge clk);
        #(drive_delay);
        drive_inputs();
        @(negedge clk);
        observe();
    endtask

    task automatic drain();
        logic busy;
        busy = 1'b1;
        while (busy) begin
            run_cycle();
            busy = out_valid || (wb_q.size() != 0) || (in_valid != '0);
            for (int w = 0; w < num_warps; w++) begin
                if (stream_q[w].size() != 0 || expect_q[w].size() != 0) busy = 1'b1;
            end
        end
        // Idle cycles catch anything issued twice
        repeat (4) run_cycle();
    endtask

    task automatic stream_test(input string name, input int per_warp, input logic allow_wb);
        stall_base  = stall_count;
        quiet_stall = !allow_wb;
        for (int w = 0; w < num_warps; w++) begin
            add_stream(w, per_warp, allow_wb);
        end
        drain();
        quiet_stall = 1'b0;
        end_test(name);
    endtask

    // Warp 0 writes r5 and its reader waits well past the stall limit
    task automatic timeout_test();
        issue_instr_t writer;
        issue_instr_t reader;
        int           target;
        logic         seen_high;
        logic         others_high;
        logic         wb_seen;
        writer         = '0;
        writer.tag     = 8'hf0;
        writer.wb      = 1'b1;
        writer.rd      = reg_idx_t'(5);
        reader         = '0;
        reader.tag     = 8'hf1;
        reader.used_rs = 3'b001;
        reader.rs1     = reg_idx_t'(5);
        seen_high      = 1'b0;
        others_high    = 1'b0;
        wb_seen        = 1'b0;
        backpressure   = 1'b0;
        steady_inputs  = 1'b1;
        wb_delay_fixed = wb_hold;
        target         = issued_count[0] + 2;
        stream_q[0].push_back(writer);
        stream_q[0].push_back(reader);
        while (issued_count[0] < target) begin
            run_cycle();
            if (stall_timeout[0] && !wb_seen) seen_high = 1'b1;
            if (stall_timeout[num_warps-1:1] != '0) others_high = 1'b1;
            if (wb_valid) wb_seen = 1'b1;
        end
        check_equal("warp 0 timeout before the writeback", 64'(seen_high), 64'(1));
        check_equal("warp 0 timeout after the reader issued", 64'(stall_timeout[0]), 64'(0));
        check_equal("timeout on the idle warps", 64'(others_high), 64'(0));
        drain();
        end_test("stall_timeout");
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles before the streams drained", watchdog_cycles);
        $display("test failed");
        $finish;
    end

    initial begin
        lfsr_state     = 32'h4344;
        reset          = 1'b1;
        in_valid       = '0;
        in_instr       = '0;
        out_ready      = 1'b0;
        wb_valid       = 1'b0;
        wb_data        = '0;
        cyc            = 0;
        test_errors    = 0;
        pass_count     = 0;
        fail_count     = 0;
        wb_delay_fixed = 0;
        taken          = '0;
        backpressure   = 1'b1;
        steady_inputs  = 1'b0;
        quiet_stall    = 1'b0;
        stall_base     = '0;
        stall_prev     = '0;
        prev_valid     = 1'b0;
        prev_ready     = 1'b0;
        prev_out       = '0;
        for (int w = 0; w < num_warps; w++) begin
            pending_regs[w] = '0;
            next_tag[w]     = '0;
            issued_count[w] = 0;
        end
        repeat (9) @(posedge clk);
        @(negedge clk);
        check_equal("in_ready during reset", 64'(in_ready), 64'(0));
        @(posedge clk);
        #(drive_delay);
        reset = 1'b0;
        @(negedge clk);
        check_equal("out_valid after reset", 64'(out_valid), 64'(0));
        check_equal("stall_timeout after reset", 64'(stall_timeout), 64'(0));
        check_equal("stall_count after reset", 64'(stall_count), 64'(0));
        end_test("reset_values");
        stream_test("no_writes", quiet_per_warp, 1'b0);
        stream_test("random_hazards", random_per_warp, 1'b1);
        timeout_test();
        $display("passing tests: %0d, failing tests: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== rtl/issue_stage.sv ====
// Issue stage top level
`timescale 1ns/1ps
`include "issue_settings.svh"

module issue_stage import issue_pkg::*; (
    input  logic                                clk,
    input  logic                                reset,

    input  logic [`ISSUE_NUM_WARPS-1:0]         in_valid,
    input  issue_instr_t [`ISSUE_NUM_WARPS-1:0] in_instr,
    output logic [`ISSUE_NUM_WARPS-1:0]         in_ready,

    output logic                                out_valid,
    output issued_instr_t                       out_instr,
    input  logic                                out_ready,

    input  logic                                wb_valid,
    input  writeback_t                          wb_data,

    output logic [`ISSUE_CTR_BITS-1:0]          stall_count,
    output logic [`ISSUE_NUM_WARPS-1:0]         stall_timeout
);

    localparam int num_warps = `ISSUE_NUM_WARPS;

    logic [num_warps-1:0]         in_fire;
    logic [num_warps-1:0]         stg_valid;
    issue_instr_t [num_warps-1:0] stg_instr;
    logic [num_warps-1:0]         stg_ready;
    logic [num_warps-1:0]         stg_fire;
    logic [num_warps-1:0]         operands_ready;
    logic [num_warps-1:0]         req;
    logic [num_warps-1:0]         grant;

    assign in_fire  = in_valid & in_ready;
    assign stg_fire = stg_valid & stg_ready;

    for (genvar w = 0; w < num_warps; w++) begin : g_warp
        staging_buffer staging_buffer_inst (
            .clk       (clk),
            .reset     (reset),
            .in_valid  (in_valid[w]),
            .in_instr  (in_instr[w]),
            .in_ready  (in_ready[w]),
            .stg_valid (stg_valid[w]),
            .stg_instr (stg_instr[w]),
            .stg_ready (stg_ready[w])
        );

        reg_scoreboard #(
            .warp_id (w)
        ) reg_scoreboard_inst (
            .clk            (clk),
            .reset          (reset),
            .in_fire        (in_fire[w]),
            .in_instr       (in_instr[w]),
            .stg_valid      (stg_valid[w]),
            .stg_instr      (stg_instr[w]),
            .stg_fire       (stg_fire[w]),
            .wb_valid       (wb_valid),
            .wb_data        (wb_data),
            .operands_ready (operands_ready[w])
        );

        // Only warps with clean operands compete for the issue slot
        assign req[w]       = stg_valid[w] && operands_ready[w];
        assign stg_ready[w] = grant[w] && operands_ready[w];
    end

    issue_arbiter issue_arbiter_inst (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .req_instr (stg_instr),
        .grant     (grant),
        .out_valid (out_valid),
        .out_instr (out_instr),
        .out_ready (out_ready)
    );

    stall_monitor stall_monitor_inst (
        .clk            (clk),
        .reset          (reset),
        .stg_valid      (stg_valid),
        .operands_ready (operands_ready),
        .stg_fire       (stg_fire),
        .stall_count    (stall_count),
        .stall_timeout  (stall_timeout)
    );

endmodule

// ==== rtl/stall_monitor.sv ====
// Issue stall monitor
`timescale 1ns/1ps
`include "issue_settings.svh"

module stall_monitor (
    input  logic                         clk,
    input  logic                         reset,

    input  logic [`ISSUE_NUM_WARPS-1:0]  stg_valid,
    input  logic [`ISSUE_NUM_WARPS-1:0]  operands_ready,
    input  logic [`ISSUE_NUM_WARPS-1:0]  stg_fire,

    output logic [`ISSUE_CTR_BITS-1:0]   stall_count,
    output logic [`ISSUE_NUM_WARPS-1:0]  stall_timeout
);

    localparam int num_warps = `ISSUE_NUM_WARPS;
    localparam int ctr_bits  = `ISSUE_CTR_BITS;
    localparam int timer_w   = $clog2(`ISSUE_STALL_TIMEOUT + 1);
    localparam logic [timer_w-1:0] timeout_val = timer_w'(`ISSUE_STALL_TIMEOUT);

    logic                             stall;
    logic [num_warps-1:0][timer_w-1:0] timer;

    // Work is waiting but every staged warp is blocked on operands
    assign stall = (|stg_valid) && !(|(stg_valid & operands_ready));

    always_ff @(posedge clk) begin
        if (reset) begin
            stall_count <= '0;
        end else if (stall) begin
            stall_count <= stall_count + ctr_bits'(1);
        end
    end

    for (genvar w = 0; w < num_warps; w++) begin : g_timer
        always_ff @(posedge clk) begin
            if (reset || stg_fire[w]) begin
                timer[w] <= '0;
            end else if (stg_valid[w] && (timer[w] != timeout_val)) begin
                timer[w] <= timer[w] + timer_w'(1);
            end
        end

        // Timer saturates, so the flag stays up until the warp fires
        assign stall_timeout[w] = (timer[w] == timeout_val);
    end

endmodule

// ==== rtl/issue_arbiter.sv ====
// Round-robin issue arbiter
`timescale 1ns/1ps
`include "issue_settings.svh"

module issue_arbiter import issue_pkg::*; (
    input  logic                                clk,
    input  logic                                reset,

    input  logic [`ISSUE_NUM_WARPS-1:0]         req,
    input  issue_instr_t [`ISSUE_NUM_WARPS-1:0] req_instr,
    output logic [`ISSUE_NUM_WARPS-1:0]         grant,

    output logic                                out_valid,
    output issued_instr_t                       out_instr,
    input  logic                                out_ready
);

    localparam int num_warps = `ISSUE_NUM_WARPS;

    warp_idx_t last_grant;
    warp_idx_t cand;
    warp_idx_t sel;
    logic      found;
    logic      take;

    // The output register is free when empty or being read this cycle
    assign take = !out_valid || out_ready;

    always_comb begin
        grant = '0;
        sel   = last_grant;
        cand  = last_grant;
        found = 1'b0;
        // Search starts one past the warp granted last
        for (int k = 1; k <= num_warps; k++) begin
            cand = warp_idx_t'((int'(last_grant) + k) % num_warps);
            if (take && !found && req[cand]) begin
                found = 1'b1;
                sel   = cand;
            end
        end
        if (found) begin
            grant[sel] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            last_grant <= warp_idx_t'(num_warps - 1);
        end else if (take) begin
            out_valid <= found;
            if (found) begin
                last_grant <= sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && found) begin
            out_instr.wid   <= sel;
            out_instr.instr <= req_instr[sel];
        end
    end

    grant_onehot_check: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant) && ((grant & ~req) == '0));

endmodule

// ==== rtl/reg_scoreboard.sv ====
// Per-warp register scoreboard
`timescale 1ns/1ps
`include "issue_settings.svh"

module reg_scoreboard import issue_pkg::*; #(
    parameter int warp_id = 0
) (
    input  logic         clk,
    input  logic         reset,

    input  logic         in_fire,
    input  issue_instr_t in_instr,

    input  logic         stg_valid,
    input  issue_instr_t stg_instr,
    input  logic         stg_fire,

    input  logic         wb_valid,
    input  writeback_t   wb_data,

    output logic         operands_ready
);

    localparam int num_regs = `ISSUE_NUM_REGS;

    logic [num_regs-1:0] pending;
    logic [num_regs-1:0] pending_n;
    logic [num_regs-1:0] in_mask;
    logic [num_regs-1:0] stg_mask;
    logic [num_regs-1:0] next_mask;
    logic                wb_fire;

    // One bit per register the instruction reads or writes
    function automatic logic [num_regs-1:0] opd_mask(input issue_instr_t instr);
        logic [num_regs-1:0] mask;
        mask = '0;
        if (instr.wb) begin
            mask[instr.rd] = 1'b1;
        end
        if (instr.used_rs[0]) begin
            mask[instr.rs1] = 1'b1;
        end
        if (instr.used_rs[1]) begin
            mask[instr.rs2] = 1'b1;
        end
        if (instr.used_rs[2]) begin
            mask[instr.rs3] = 1'b1;
        end
        return mask;
    endfunction

    assign wb_fire  = wb_valid && (wb_data.wid == warp_idx_t'(warp_id));
    assign in_mask  = opd_mask(in_instr);
    assign stg_mask = stg_valid ? opd_mask(stg_instr) : '0;

    // Whatever sits in staging next cycle is checked against next cycle's table
    assign next_mask = in_fire ? in_mask : stg_mask;

    always_comb begin
        pending_n = pending;
        if (wb_fire) begin
            pending_n[wb_data.rd] = 1'b0;
        end
        if (stg_fire && stg_instr.wb) begin
            pending_n[stg_instr.rd] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending        <= '0;
            operands_ready <= 1'b0;
        end else begin
            pending        <= pending_n;
            operands_ready <= ~|(pending_n & next_mask);
        end
    end

    // Execution must only retire registers this warp marked as busy
    wb_pending_check: assert property (@(posedge clk) disable iff (reset)
        wb_fire |-> pending[wb_data.rd]);

    // The top level may only drain staging once the operand check passed
    fire_ready_check: assert property (@(posedge clk) disable iff (reset)
        stg_fire |-> (stg_valid && operands_ready));

endmodule

// ==== rtl/staging_buffer.sv ====
// Per-warp staging buffer
`timescale 1ns/1ps

module staging_buffer import issue_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    input  logic         in_valid,
    input  issue_instr_t in_instr,
    output logic         in_ready,

    output logic         stg_valid,
    output issue_instr_t stg_instr,
    input  logic         stg_ready
);

    logic in_fire;

    // A full entry can be refilled in the cycle it drains
    assign in_ready = !reset && (!stg_valid || stg_ready);
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            stg_valid <= 1'b0;
        end else if (in_fire) begin
            stg_valid <= 1'b1;
        end else if (stg_ready) begin
            stg_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            stg_instr <= in_instr;
        end
    end

endmodule

// ==== rtl/issue_pkg.sv ====
// Issue stage types
`include "issue_settings.svh"

package issue_pkg;

    typedef logic [$clog2(`ISSUE_NUM_REGS)-1:0] reg_idx_t;
    typedef logic [$clog2(`ISSUE_NUM_WARPS)-1:0] warp_idx_t;

    // One decoded instruction as delivered by the instruction buffer
    typedef struct packed {
        logic [7:0] tag;
        logic [5:0] op;
        logic       wb;
        // Bit 0 is rs1, bit 1 is rs2, bit 2 is rs3
        logic [2:0] used_rs;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rs3;
    } issue_instr_t;

    typedef struct packed {
        warp_idx_t    wid;
        issue_instr_t instr;
    } issued_instr_t;

    // Final writeback of one destination register
    typedef struct packed {
        warp_idx_t wid;
        reg_idx_t  rd;
    } writeback_t;

endpackage

// ==== rtl/issue_settings.svh ====
// Issue stage settings
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// Warps sharing one issue stage
`define ISSUE_NUM_WARPS 4

// Integer registers per warp
`define ISSUE_NUM_REGS 32

// Cycles a staged warp may wait before its timeout flag rises
`define ISSUE_STALL_TIMEOUT 64

// Width of the stall cycle counter
`define ISSUE_CTR_BITS 16

`endif
